// File: hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam reg_idx_t link_reg = 5'd31; // jal target register.

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function field of special opcode.
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        dest_rd   = 2'b00,
        dest_rt   = 2'b01,
        dest_link = 2'b10
    } dest_kind_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_t    alu_op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        word_t      rs_val;
        word_t      rt_val;
        word_t      imm;
        logic       use_imm;
        logic       reg_write;
        dest_kind_t dest_kind;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jump;
        logic       is_link;
        word_t      jump_target;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        word_t      result;
        word_t      store_data;
        logic       reg_write;
        dest_kind_t dest_kind;
        reg_idx_t   rd;
        reg_idx_t   rt;
        logic       mem_read;
        logic       mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        logic       reg_write;
        dest_kind_t dest_kind;
        reg_idx_t   rd;
        reg_idx_t   rt;
        word_t      value;
    } mem_wb_t;

    // register actually written, by destination kind.
    function automatic reg_idx_t dest_index(dest_kind_t kind, reg_idx_t rd, reg_idx_t rt);
        case (kind)
            dest_rd:   return rd;
            dest_rt:   return rt;
            dest_link: return link_reg;
            default:   return '0;
        endcase
    endfunction

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; #(
    parameter word_t reset_vector = 32'h0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall_load,
    input  logic   hold,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output word_t  imem_addr,
    input  word_t  imem_data,
    output if_id_t if_id
);

    word_t pc;

    assign imem_addr = pc; // rom answers in the same cycle.

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= reset_vector;
            if_id.valid <= 1'b0;
        end else if (redirect) begin
            // kill the instruction now in decode slot.
            pc          <= redirect_pc;
            if_id.valid <= 1'b0;
        end else if (!(stall_load || hold)) begin
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    input  logic    hold,
    input  logic    redirect,
    output logic    stall_load,
    output id_ex_t  id_ex
);

    word_t       regs [32];
    opcode_t     op;
    funct_t      funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] imm16;
    word_t       rs_val;
    word_t       rt_val;
    word_t       pc_plus4;
    reg_idx_t    wr_idx;
    logic        wr_en;
    reg_idx_t    ld_dst;
    id_ex_t      dec;

    assign op       = opcode_t'(if_id.instr[31:26]);
    assign funct    = funct_t'(if_id.instr[5:0]);
    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign rd       = if_id.instr[15:11];
    assign imm16    = if_id.instr[15:0];
    assign pc_plus4 = if_id.pc + 32'd4;

    // writeback port.
    assign wr_idx = dest_index(mem_wb.dest_kind, mem_wb.rd, mem_wb.rt);
    assign wr_en  = mem_wb.valid && mem_wb.reg_write && wr_idx != '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_idx] <= mem_wb.value;
        end
    end

    // write-first read, r0 hardwired.
    assign rs_val = (rs == '0) ? '0 : (wr_en && wr_idx == rs) ? mem_wb.value : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wr_en && wr_idx == rt) ? mem_wb.value : regs[rt];

    always_comb begin
        dec             = '0;
        dec.valid       = if_id.valid;
        dec.pc          = if_id.pc;
        dec.alu_op      = alu_add;
        dec.rs          = rs;
        dec.rt          = rt;
        dec.rd          = rd;
        dec.rs_val      = rs_val;
        dec.rt_val      = rt_val;
        dec.imm         = {{16{imm16[15]}}, imm16};
        dec.dest_kind   = dest_rd;
        dec.jump_target = {pc_plus4[31:28], if_id.instr[25:0], 2'b00};
        case (op)
            op_special: begin
                dec.reg_write = 1'b1;
                case (funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.reg_write = 1'b0; // unsupported, acts as nop.
                endcase
            end
            op_addiu, op_lw: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest_kind = dest_rt;
                dec.mem_read  = (op == op_lw);
            end
            op_andi, op_ori: begin
                dec.alu_op    = (op == op_andi) ? alu_and : alu_or;
                dec.imm       = {16'h0, imm16};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest_kind = dest_rt;
            end
            op_lui: begin
                dec.alu_op    = alu_lui;
                dec.imm       = {imm16, 16'h0};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest_kind = dest_rt;
            end
            op_sw: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            op_beq:  dec.is_branch = 1'b1;
            op_j:    dec.is_jump = 1'b1;
            op_jal: begin
                dec.is_jump   = 1'b1;
                dec.is_link   = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest_kind = dest_link;
            end
            default: ;
        endcase
    end

    // load in execute feeding this instruction.
    assign ld_dst     = dest_index(id_ex.dest_kind, id_ex.rd, id_ex.rt);
    assign stall_load = if_id.valid && id_ex.valid && id_ex.mem_read && ld_dst != '0
                        && (ld_dst == rs || ld_dst == rt);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (!hold) begin
            if (redirect || stall_load) begin
                id_ex.valid <= 1'b0; // bubble.
            end else begin
                id_ex <= dec;
            end
        end
    end

endmodule

// File: hw/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import mips_pkg::*; (
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    reg_idx_t ex_dst;
    reg_idx_t wb_dst;
    logic     ex_live;
    logic     wb_live;

    // newest producer wins.
    function automatic fwd_sel_t pick_source(
        reg_idx_t src,
        logic     mem_live,
        reg_idx_t mem_dst,
        logic     last_live,
        reg_idx_t last_dst
    );
        if (mem_live && mem_dst == src) begin
            return fwd_mem;
        end else if (last_live && last_dst == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign ex_dst  = dest_index(ex_mem.dest_kind, ex_mem.rd, ex_mem.rt);
    assign wb_dst  = dest_index(mem_wb.dest_kind, mem_wb.rd, mem_wb.rt);

    // r0 writes are dropped, never forwarded.
    assign ex_live = ex_mem.valid && ex_mem.reg_write && ex_dst != '0;
    assign wb_live = mem_wb.valid && mem_wb.reg_write && wb_dst != '0;

    assign fwd_a = pick_source(id_rs, ex_live, ex_dst, wb_live, wb_dst);
    assign fwd_b = pick_source(id_rt, ex_live, ex_dst, wb_live, wb_dst);

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    ex_mem_fwd,
    input  word_t    wb_fwd,
    input  logic     hold,
    output logic     redirect,
    output word_t    redirect_pc,
    output ex_mem_t  ex_mem
);

    word_t   op_a;
    word_t   rt_fwd;
    word_t   op_b;
    word_t   alu_out;
    word_t   pc_plus4;
    word_t   branch_target;
    logic    taken;
    ex_mem_t nxt;

    function automatic word_t operand(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = operand(fwd_a, id_ex.rs_val, ex_mem_fwd, wb_fwd);
    assign rt_fwd = operand(fwd_b, id_ex.rt_val, ex_mem_fwd, wb_fwd);
    assign op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_lui: alu_out = op_b; // upper half already placed by decode.
            default: alu_out = op_a + op_b;
        endcase
    end

    assign pc_plus4      = id_ex.pc + 32'd4;
    assign branch_target = pc_plus4 + {id_ex.imm[29:0], 2'b00};

    assign taken       = id_ex.valid && (id_ex.is_jump || (id_ex.is_branch && op_a == rt_fwd));
    assign redirect    = taken && !hold; // held instruction redirects once released.
    assign redirect_pc = id_ex.is_jump ? id_ex.jump_target : branch_target;

    always_comb begin
        nxt            = '0;
        nxt.valid      = id_ex.valid;
        nxt.result     = id_ex.is_link ? pc_plus4 : alu_out;
        nxt.store_data = rt_fwd;
        nxt.reg_write  = id_ex.reg_write;
        nxt.dest_kind  = id_ex.dest_kind;
        nxt.rd         = id_ex.rd;
        nxt.rt         = id_ex.rt;
        nxt.mem_read   = id_ex.mem_read;
        nxt.mem_write  = id_ex.mem_write;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (!hold) begin
            ex_mem <= nxt;
        end
    end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output logic    hold,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output word_t   wb_adr,
    output word_t   wb_dat_w,
    input  word_t   wb_dat_r,
    input  logic    wb_ack,
    output mem_wb_t mem_wb
);

    typedef enum logic {
        st_ready,
        st_recover
    } bus_state_t;

    bus_state_t state;
    logic       req;
    logic       done;

    assign req = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // request comes straight from the held ex/mem register.
    assign wb_cyc   = req && state == st_ready;
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc && ex_mem.mem_write;
    assign wb_adr   = ex_mem.result;
    assign wb_dat_w = ex_mem.store_data;

    assign done = wb_cyc && wb_ack;
    assign hold = req && !done;

    // one idle cycle after each ack.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_ready;
        end else if (done) begin
            state <= st_recover;
        end else begin
            state <= st_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else if (!hold) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.dest_kind <= ex_mem.dest_kind;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.rt        <= ex_mem.rt;
            mem_wb.value     <= ex_mem.mem_read ? wb_dat_r : ex_mem.result; // load data on ack.
        end
    end

endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
    parameter word_t reset_vector = 32'h0
) (
    input  logic  clk,
    input  logic  reset,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output word_t wb_adr,
    output word_t wb_dat_w,
    input  word_t wb_dat_r,
    input  logic  wb_ack
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     stall_load;
    logic     hold;
    logic     redirect;
    word_t    redirect_pc;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    fetch_stage #(
        .reset_vector(reset_vector)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .stall_load (stall_load),
        .hold       (hold),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .if_id     (if_id),
        .mem_wb    (mem_wb),
        .hold      (hold),
        .redirect  (redirect),
        .stall_load(stall_load),
        .id_ex     (id_ex)
    );

    forwarding_unit u_fwd (
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .id_rs (id_ex.rs),
        .id_rt (id_ex.rt),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .id_ex      (id_ex),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .ex_mem_fwd (ex_mem.result),
        .wb_fwd     (mem_wb.value),
        .hold       (hold),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .ex_mem     (ex_mem)
    );

    memory_stage u_memory (
        .clk     (clk),
        .reset   (reset),
        .ex_mem  (ex_mem),
        .hold    (hold),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .mem_wb  (mem_wb)
    );

endmodule

// File: test/mips_core_props.sv
`timescale 1ns/1ps

module mips_core_props (
    input logic        clk,
    input logic        reset,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [31:0] wb_adr,
    input logic [31:0] wb_dat_w,
    input logic        wb_ack
);

    // bus idle in the cycle after any reset edge.
    reset_idle: assert property (@(posedge clk) reset |=> (!wb_cyc && !wb_stb))
        else $error("bus active during or after reset");

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // master holds the request until ack.
    req_held: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> wb_stb)
        else $error("wb_stb dropped before ack");

    req_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("request changed while waiting for ack");

endmodule

bind mips_core mips_core_props u_props (
    .clk     (clk),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_ack  (wb_ack)
);

// File: test/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam logic [31:0] reset_vector = 32'h0;
    localparam realtime clk_period = 4.0;
    localparam int max_instr = 200;
    localparam int cycles_per_instr = 10;
    localparam realtime timeout = max_instr * cycles_per_instr * clk_period;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] rom [256];
    logic [31:0] dmem [256];
    logic        busy;
    int unsigned wait_left;

    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int          n_expected;
    int          stores_seen;
    logic [31:0] loop_pc;

    mips_core #(
        .reset_vector(reset_vector)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    assign imem_data = rom[imem_addr[9:2]]; // combinational rom.

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] fill_word(int unsigned i);
        return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    endfunction

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // sequential reference run of the program, records every store.
    task automatic run_golden();
        logic [31:0] r [32];
        logic [31:0] mm [256];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] nxt;
        logic [31:0] sx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [5:0]  op;
        int          steps;
        bit          done;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) mm[i] = fill_word(i);
        pc = reset_vector;
        steps = 0;
        done = 0;
        while (!done && steps < max_instr) begin
            ins  = rom[pc[9:2]];
            op   = ins[31:26];
            nxt  = pc + 4;
            sx   = {{16{ins[15]}}, ins[15:0]};
            a    = r[ins[25:21]];
            b    = r[ins[20:16]];
            addr = a + sx;
            case (op)
                6'h00: begin
                    case (ins[5:0])
                        6'h21: r[ins[15:11]] = a + b;
                        6'h23: r[ins[15:11]] = a - b;
                        6'h24: r[ins[15:11]] = a & b;
                        6'h25: r[ins[15:11]] = a | b;
                        6'h2a: r[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                6'h09: r[ins[20:16]] = a + sx;
                6'h0c: r[ins[20:16]] = a & {16'h0, ins[15:0]};
                6'h0d: r[ins[20:16]] = a | {16'h0, ins[15:0]};
                6'h0f: r[ins[20:16]] = {ins[15:0], 16'h0};
                6'h23: r[ins[20:16]] = mm[addr[9:2]];
                6'h2b: begin
                    mm[addr[9:2]] = b;
                    exp_adr.push_back(addr);
                    exp_dat.push_back(b);
                end
                6'h04: if (a == b) nxt = pc + 4 + (sx << 2);
                6'h02, 6'h03: begin
                    nxt = {nxt[31:28], ins[25:0], 2'b00}; // region of pc + 4.
                    if (op == 6'h03) r[31] = pc + 4;
                    if (op == 6'h02 && nxt == pc) done = 1; // self loop reached.
                end
                default: ;
            endcase
            r[0] = '0;
            if (!done) begin
                pc = nxt;
            end
            steps++;
        end
        loop_pc = pc;
        n_expected = exp_adr.size();
        if (!done) begin
            $display("golden model did not reach a self loop within %0d instructions",
                     max_instr);
            fail_run();
        end
    endtask

    // wishbone slave with 0 to 3 wait states.
    always @(posedge clk) begin
        int unsigned n;
        if (reset) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            n = 0;
            if (busy) begin
                n = wait_left;
            end else begin
                n = $urandom % 4;
            end
            if (n == 0) begin
                wb_ack <= 1'b1;
                busy   <= 1'b0;
                if (wb_we) begin
                    dmem[wb_adr[9:2]] <= wb_dat_w;
                end else begin
                    wb_dat_r <= dmem[wb_adr[9:2]];
                end
            end else begin
                busy      <= 1'b1;
                wait_left <= n - 1;
            end
        end
    end

    // compare each acknowledged write with the next golden store.
    always @(posedge clk) begin
        logic [31:0] ea;
        logic [31:0] ed;
        if (!reset && wb_ack && wb_we) begin
            if (exp_adr.size() == 0) begin
                $display("store to %h with data %h that the program never makes",
                         wb_adr, wb_dat_w);
                fail_run();
            end else begin
                ea = exp_adr.pop_front();
                ed = exp_dat.pop_front();
                stores_seen++;
                assert (wb_adr == ea && wb_dat_w == ed) else begin
                    if (wb_adr != ea) begin
                        $display("CHECK FAILED wb_adr got %h expected %h", wb_adr, ea);
                    end
                    if (wb_dat_w != ed) begin
                        $display("CHECK FAILED wb_dat_w got %h expected %h", wb_dat_w, ed);
                    end
                    fail_run();
                end
            end
        end
    end

    initial begin
        #(timeout);
        $display("timeout after %0t, core did not finish the program", $time);
        fail_run();
    end

    initial begin
        void'($urandom(59776));
        reset       = 1'b1;
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        busy        = 1'b0;
        wait_left   = 0;
        stores_seen = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i]  = '0; // nop past the program.
            dmem[i] = fill_word(i);
        end
        $readmemh("program.hex", rom);
        run_golden();

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (imem_addr == reset_vector) else begin
            $display("CHECK FAILED imem_addr got %h expected %h", imem_addr, reset_vector);
            fail_run();
        end

        while (imem_addr != loop_pc) @(negedge clk);
        repeat (20) @(posedge clk); // last stores drain, stray ones fail the checker.
        if (stores_seen == n_expected) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("store count %0d differs from expected %0d", stores_seen, n_expected);
            fail_run();
        end
    end

endmodule

// File: all.f
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/forwarding_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_core.sv
test/mips_core_props.sv
test/tb_mips_core.sv

// File: program.hex
// one 32-bit instruction word per line, word address 0 upward.
// expected stores as (byte address, data) are listed after each sw.
24010005 // addiu $1,$0,5
24220003 // addiu $2,$1,3
00221821 // addu  $3,$1,$2
00612023 // subu  $4,$3,$1
AC040000 // sw    $4,0($0)   (0x00, 8)
00832825 // or    $5,$4,$3
AC050004 // sw    $5,4($0)   (0x04, 13)
8C060004 // lw    $6,4($0)
00C13821 // addu  $7,$6,$1
AC070008 // sw    $7,8($0)   (0x08, 18)
3C081234 // lui   $8,0x1234
35085678 // ori   $8,$8,0x5678
0088482A // slt   $9,$4,$8
310AFF00 // andi  $10,$8,0xff00
AC0A000C // sw    $10,12($0) (0x0c, 0x5600)
11200002 // beq   $9,$0,+2 not taken
0C000014 // jal   word 20
240B0077 // addiu $11,$0,0x77 skipped
AC0B0010 // sw    $11,16($0) skipped
00000000 // nop
03E16021 // addu  $12,$31,$1
AC1F0014 // sw    $31,20($0) (0x14, 0x44)
118C0001 // beq   $12,$12,+1 taken
AC0C0018 // sw    $12,24($0) skipped
8C0D0000 // lw    $13,0($0)
AC0D0018 // sw    $13,24($0) (0x18, 8)
AC0C001C // sw    $12,28($0) (0x1c, 73)
0800001B // j     word 27, self loop
